// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       := mlu_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

# sources are taken from the file list, without +incdir+ lines.
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the binary reads bench/mlu_tests.txt relative to the project root.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mlu_tb.sv
module mlu_tb import mlu_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_slices = 4;
  localparam int data_width = num_slices * slice_width;

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  logic [data_width-1:0] a;
  logic [data_width-1:0] b;
  mlu_op_t               op;
  logic                  carry_in;
  logic [data_width-1:0] result;
  logic                  carry_out;
  logic                  zero;
  logic                  valid;

  // vectors as read from the file with one entry per line.
  logic [2:0]            vec_op[$];
  logic [data_width-1:0] vec_a[$];
  logic [data_width-1:0] vec_b[$];
  logic                  vec_cin[$];
  logic [data_width-1:0] vec_res[$];
  logic                  vec_carry[$];
  logic                  vec_zero[$];

  // expected responses of the operations in flight with the oldest first.
  logic [data_width-1:0] exp_result_q[$];
  logic                  exp_carry_q[$];
  logic                  exp_zero_q[$];

  int cycle_count = 0;
  int cycle_limit = 0;
  int negedge_count = 0;
  int first_start_edge = 0;
  int results_seen = 0;
  bit start_seen = 0;
  bit first_valid_seen = 0;

  mlu_top #(.num_slices(num_slices)) u_dut (
    .clk(clk), .rst_n(rst_n), .start(start), .a(a), .b(b), .op(op),
    .carry_in(carry_in), .result(result), .carry_out(carry_out), .zero(zero),
    .valid(valid)
  );

  always #4 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // failure reporting and comparison
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error.");
  endtask

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR: %s is 0x%h, expected 0x%h", name, actual, expected);
      fail_run("value mismatch.");
    end
  endtask

  task automatic load_vectors();
    int fd;
    int count;
    string line;
    logic [31:0] f_op, f_a, f_b, f_cin, f_res, f_carry, f_zero;
    fd = $fopen("bench/mlu_tests.txt", "r");
    if (fd == 0) begin
      fail_run("the vector file bench/mlu_tests.txt could not be opened.");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        count = $fgets(line, fd);
        if (count > 0 && line.len() > 1 && line[0] != "#") begin
          count = $sscanf(line, "%h %h %h %h %h %h %h",
                          f_op, f_a, f_b, f_cin, f_res, f_carry, f_zero);
          if (count != 7) begin
            fail_run("a line of the vector file does not hold seven fields.");
          end
          vec_op.push_back(f_op[2:0]);
          vec_a.push_back(f_a[data_width-1:0]);
          vec_b.push_back(f_b[data_width-1:0]);
          vec_cin.push_back(f_cin[0]);
          vec_res.push_back(f_res[data_width-1:0]);
          vec_carry.push_back(f_carry[0]);
          vec_zero.push_back(f_zero[0]);
        end
      end
      $fclose(fd);
      if (vec_op.size() == 0) begin
        fail_run("the vector file holds no vectors.");
      end
      cycle_limit = vec_op.size() + 20; // reset, latency and drain fit in the margin.
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // timeout and result monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      fail_run("timeout: the run took more cycles than the vectors need.");
    end
  end

  // outputs are looked at on the falling edge half a cycle after they change.
  always @(negedge clk) begin
    negedge_count++;
    if (!start_seen) begin
      check_value("valid", 32'(valid), 32'd0); // nothing may come out before a start.
      if (start === 1'b1) begin
        start_seen = 1'b1;
        first_start_edge = negedge_count;
      end
    end else if (valid === 1'b1) begin
      if (!first_valid_seen) begin
        first_valid_seen = 1'b1;
        check_value("valid latency", 32'(negedge_count - first_start_edge), 32'd2);
      end
      if (exp_result_q.size() == 0) begin
        fail_run("valid was high with no operation in flight.");
      end
      check_value("result", 32'(result), 32'(exp_result_q.pop_front()));
      check_value("carry_out", 32'(carry_out), 32'(exp_carry_q.pop_front()));
      check_value("zero", 32'(zero), 32'(exp_zero_q.pop_front()));
      results_seen++;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    a = '0;
    b = '0;
    op = mlu_add;
    carry_in = 1'b0;
    load_vectors();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < vec_op.size(); i++) begin
      @(posedge clk);
      start <= 1'b1; // one vector every cycle.
      a <= vec_a[i];
      b <= vec_b[i];
      op <= mlu_op_t'(vec_op[i]);
      carry_in <= vec_cin[i];
      exp_result_q.push_back(vec_res[i]);
      exp_carry_q.push_back(vec_carry[i]);
      exp_zero_q.push_back(vec_zero[i]);
    end
    @(posedge clk);
    start <= 1'b0;
    while (results_seen < vec_op.size()) @(negedge clk);
    repeat (3) @(posedge clk); // an idle DUT must not raise valid again.
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: bench/mlu_tests.txt
# columns in hex: op a b carry_in expected_result expected_carry expected_zero
# op codes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 not, 6 and 7 no-operation
0 00ff 0001 0 0100 0 0
0 ffff 0001 0 0000 1 1
0 1234 4321 1 5556 0 0
0 0000 0000 0 0000 0 1
0 ffff ffff 1 ffff 1 0
0 8000 8000 0 0000 1 1
0 0fff 0000 1 1000 0 0
0 abcd 1234 0 be01 0 0
0 ffff 0000 1 0000 1 1
0 7fff 7fff 0 fffe 0 0
1 1234 0234 1 1000 1 0
1 0000 0001 1 ffff 0 0
1 5555 5555 1 0000 1 1
1 0010 0001 1 000f 1 0
1 8000 0001 1 7fff 1 0
1 1234 0234 0 0fff 1 0
1 0001 ffff 1 0002 0 0
1 ffff 0000 1 ffff 1 0
2 f0f0 ff00 0 f000 0 0
2 aaaa 5555 0 0000 0 1
2 ffff 1234 1 1234 0 0
3 f000 000f 0 f00f 0 0
3 0000 0000 1 0000 0 1
3 1234 4321 0 5335 0 0
4 ffff 0f0f 0 f0f0 0 0
4 abcd abcd 0 0000 0 1
4 1234 ffff 1 edcb 0 0
5 0000 1234 0 ffff 0 0
5 ffff 0000 0 0000 0 1
5 1234 ffff 1 edcb 0 0
6 1234 5678 0 0000 0 1
6 ffff ffff 1 0000 0 1
7 abcd ef01 1 0000 0 1
7 0000 0000 0 0000 0 1
0 0001 0002 0 0003 0 0

// File: compile.f
design/mlu_pkg.sv
design/mlu_slice.sv
design/carry_lookahead.sv
design/operand_stage.sv
design/result_stage.sv
design/mlu_top.sv
bench/mlu_tb.sv

// File: design/carry_lookahead.sv
module carry_lookahead #(
  parameter int num_slices = 4
) (
  input  logic                  cin,
  input  logic [num_slices-1:0] prop,
  input  logic [num_slices-1:0] gen,
  output logic [num_slices-1:0] slice_cin,
  output logic                  carry_out
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flat carry expansion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // carry[i] is the carry into slice i, carry[num_slices] leaves the word.
  logic [num_slices:0] carry;

  // Each carry is an OR of product terms. A term starts at a source
  // (the external carry in or one slice's generate) and is ANDed with
  // the propagate bits of every slice between that source and slice i.
  always_comb begin
    logic term;
    logic acc;
    for (int i = 0; i <= num_slices; i++) begin
      acc = 1'b0;
      for (int j = 0; j <= i; j++) begin
        if (j == 0) begin
          term = cin; // the carry in counts as the lowest source.
        end else begin
          term = gen[j-1];
        end
        for (int k = j; k < i; k++) begin
          term = term & prop[k];
        end
        acc = acc | term;
      end
      carry[i] = acc;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign slice_cin = carry[num_slices-1:0]; // bit 0 reduces to cin.
  assign carry_out = carry[num_slices];

endmodule

// File: design/mlu_pkg.sv
package mlu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slice geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int slice_width = 4; // one nibble per slice.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operation codes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The encoding is fixed by the instruction decoder of the processor,
  // so the values must stay in this order.
  typedef enum logic [2:0] {
    mlu_add  = 3'd0, // a plus b plus carry in.
    mlu_sub  = 3'd1, // a plus not b plus carry in.
    mlu_and  = 3'd2,
    mlu_or   = 3'd3,
    mlu_xor  = 3'd4,
    mlu_not  = 3'd5, // inverts the first operand only.
    mlu_nop0 = 3'd6, // gives zero.
    mlu_nop1 = 3'd7  // gives zero as well.
  } mlu_op_t;

endpackage

// File: design/mlu_slice.sv
module mlu_slice import mlu_pkg::*; (
  input  logic [slice_width-1:0] a,
  input  logic [slice_width-1:0] b,
  input  mlu_op_t                op,
  input  logic                   c_in,
  output logic [slice_width-1:0] out_low,
  output logic                   prop,
  output logic                   gen,
  output logic                   zero
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // adder operand selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [slice_width-1:0] b_arith; // second operand as the adder sees it.
  logic [slice_width:0]   raw_sum; // sum before the carry in is added.
  logic                   is_arith;

  always_comb begin
    is_arith = (op == mlu_add) || (op == mlu_sub);
    if (op == mlu_sub) begin
      b_arith = ~b; // subtract is add of the complement.
    end else begin
      b_arith = b;
    end
  end

  assign raw_sum = {1'b0, a} + {1'b0, b_arith};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (op)
      mlu_add, mlu_sub: begin
        out_low = raw_sum[slice_width-1:0] + {{(slice_width-1){1'b0}}, c_in};
      end
      mlu_and: begin
        out_low = a & b;
      end
      mlu_or: begin
        out_low = a | b;
      end
      mlu_xor: begin
        out_low = a ^ b;
      end
      mlu_not: begin
        out_low = ~a;
      end
      mlu_nop0, mlu_nop1: begin
        out_low = '0;
      end
      default: begin
        out_low = '0;
      end
    endcase
  end

  // Propagate and generate do not look at c_in, which keeps the
  // lookahead free of any loop through the slice.
  assign prop = is_arith & (&raw_sum[slice_width-1:0]); // all ones passes a carry on.
  assign gen  = is_arith & raw_sum[slice_width];        // overflow of the nibble.
  assign zero = (out_low == '0);

endmodule

// File: design/mlu_top.sv
module mlu_top import mlu_pkg::*; #(
  parameter  int num_slices = 4,
  localparam int data_width = num_slices * slice_width
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  input  mlu_op_t               op,
  input  logic                  carry_in,
  output logic [data_width-1:0] result,
  output logic                  carry_out,
  output logic                  zero,
  output logic                  valid
);

  logic [data_width-1:0] a_reg;
  logic [data_width-1:0] b_reg;
  mlu_op_t               op_reg;
  logic                  cin_reg;
  logic                  busy_strobe;
  logic [data_width-1:0] slice_out;   // nibble results side by side.
  logic [num_slices-1:0] prop;
  logic [num_slices-1:0] gen;
  logic [num_slices-1:0] nibble_zero;
  logic [num_slices-1:0] slice_cin;
  logic                  carry_out_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  operand_stage #(.num_slices(num_slices)) u_operand_stage (
    .clk(clk), .rst_n(rst_n), .start(start), .a(a), .b(b), .op(op),
    .carry_in(carry_in), .a_reg(a_reg), .b_reg(b_reg), .op_reg(op_reg),
    .cin_reg(cin_reg), .busy_strobe(busy_strobe)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // processing part
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < num_slices; i++) begin : g_slice
    mlu_slice u_slice (
      .a(a_reg[i*slice_width +: slice_width]), .b(b_reg[i*slice_width +: slice_width]),
      .op(op_reg), .c_in(slice_cin[i]), .out_low(slice_out[i*slice_width +: slice_width]),
      .prop(prop[i]), .gen(gen[i]), .zero(nibble_zero[i])
    );
  end

  carry_lookahead #(.num_slices(num_slices)) u_carry_lookahead (
    .cin(cin_reg), .prop(prop), .gen(gen), .slice_cin(slice_cin),
    .carry_out(carry_out_next)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  result_stage #(.num_slices(num_slices)) u_result_stage (
    .clk(clk), .rst_n(rst_n), .busy_strobe(busy_strobe), .slice_out(slice_out),
    .slice_zero(nibble_zero), .carry_next(carry_out_next), .result(result),
    .carry_out(carry_out), .zero(zero), .valid(valid)
  );

endmodule

// File: design/operand_stage.sv
module operand_stage import mlu_pkg::*; #(
  parameter  int num_slices = 4,
  localparam int data_width = num_slices * slice_width
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  input  mlu_op_t               op,
  input  logic                  carry_in,
  output logic [data_width-1:0] a_reg,
  output logic [data_width-1:0] b_reg,
  output mlu_op_t               op_reg,
  output logic                  cin_reg,
  output logic                  busy_strobe
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand capture
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The operand registers keep their value between strobes, so the
  // processing part keeps seeing the last operation when idle.
  always_ff @(posedge clk) begin
    if (start) begin
      a_reg   <= a;
      b_reg   <= b;
      op_reg  <= op;
      cin_reg <= carry_in; // caller drives it high for a plain subtract.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // in-flight strobe
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_strobe <= 1'b0;
    end else begin
      busy_strobe <= start; // marks the cycle the registered operands are new.
    end
  end

endmodule

// File: design/result_stage.sv
module result_stage import mlu_pkg::*; #(
  parameter  int num_slices = 4,
  localparam int data_width = num_slices * slice_width
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  busy_strobe,
  input  logic [data_width-1:0] slice_out,
  input  logic [num_slices-1:0] slice_zero,
  input  logic                  carry_next,
  output logic [data_width-1:0] result,
  output logic                  carry_out,
  output logic                  zero,
  output logic                  valid
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flag forming
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic word_zero;

  assign word_zero = &slice_zero; // the word is zero only if every nibble is.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result    <= '0;
      carry_out <= 1'b0;
      zero      <= 1'b0;
    end else if (busy_strobe) begin
      result    <= slice_out;
      carry_out <= carry_next; // for subtract a one means no borrow.
      zero      <= word_zero;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // valid pulse
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One pulse per strobe. Strobes on consecutive cycles give valid
  // on consecutive cycles, so no handshake is needed.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= busy_strobe;
    end
  end

endmodule
